// File: Makefile
# Verilator build for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= decode_stage_tb
FLIST     ?= decode_stage.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

run: compile
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

// File: decode_stage.f
rtl/mips_pkg.sv
rtl/control_unit.sv
rtl/operand_fetch.sv
rtl/hazard_unit.sv
rtl/id_ex_reg.sv
rtl/decode_stage.sv
dv/decode_checker.sv
dv/decode_stage_tb.sv

// File: dv/decode_checker.sv
`timescale 1ns/1ps

module decode_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        id_valid,
    input  logic [31:0] id_instruction,
    input  logic [31:0] id_pc_4,
    input  logic        wb_enable,
    input  logic [4:0]  wb_idx,
    input  logic [31:0] wb_data,
    input  logic        stall,
    input  logic        ex_no_op,
    input  logic        pc_offset,
    input  logic        pc_overload,
    input  logic        ex_reg_write_enable,
    input  logic [1:0]  ex_mem_control,
    input  logic [2:0]  ex_alu_control,
    input  logic [31:0] ex_operand_1,
    input  logic [31:0] ex_operand_2,
    input  logic [31:0] ex_store_data,
    input  logic [4:0]  ex_reg_1_idx,
    input  logic [4:0]  ex_reg_2_idx,
    input  logic [4:0]  ex_reg_dest_idx,
    output int          err_count
);

    logic [31:0] shadow [32];             // mirror of the register file
    logic        e_no_op, e_off, e_ovl, e_we;
    logic [1:0]  e_mem;
    logic [2:0]  e_alu;
    logic [31:0] e_op1, e_op2, e_sd;
    logic [4:0]  e_i1, e_i2, e_dst;
    logic        check_data;              // data fields carry a real instruction
    logic        armed = 1'b0;            // first prediction made
    int          stall_errs = 0;
    int          value_errs = 0;

    assign err_count = stall_errs + value_errs;

    // expected ex bundle with the no_op bit set for an illegal instruction
    function automatic logic [119:0] ref_bundle(input logic [31:0] ins, input logic [31:0] pc4,
                                                input logic [31:0] r1, input logic [31:0] r2);
        logic no_op, off, ovl, we;
        logic [1:0] mem;
        logic [2:0] alu;
        logic [31:0] op1, op2, imm, jt;
        logic [4:0] i1, i2, dst;
        no_op = 1'b0;
        off   = 1'b0;
        ovl   = 1'b0;
        we    = 1'b0;
        mem = 2'b00;
        alu = mips_pkg::alu_nop;
        op1 = r1;
        op2 = r2;
        i1  = ins[25:21];
        i2  = ins[20:16];
        dst = ins[15:11];                                 // rd unless overridden
        imm = {{16{ins[15]}}, ins[15:0]};
        jt  = {pc4[31:28], ins[25:0], 2'b00};
        case (ins[31:26])
            mips_pkg::op_rtype: begin
                we = 1'b1;
                case (ins[5:0])
                    mips_pkg::fn_add: alu = mips_pkg::alu_add;
                    mips_pkg::fn_sub: alu = mips_pkg::alu_sub;
                    mips_pkg::fn_and: alu = mips_pkg::alu_and;
                    mips_pkg::fn_or:  alu = mips_pkg::alu_or;
                    mips_pkg::fn_slt: alu = mips_pkg::alu_slt;
                    mips_pkg::fn_jr: begin
                        we  = 1'b0;
                        ovl = 1'b1;
                        dst = ins[25:21];                 // jr reports rs
                    end
                    default: no_op = 1'b1;
                endcase
            end
            mips_pkg::op_j, mips_pkg::op_jal: begin
                ovl = 1'b1;
                op1 = jt;
                i1  = 5'd0;
                i2  = 5'd0;
                if (ins[31:26] == mips_pkg::op_jal) begin
                    we  = 1'b1;
                    dst = 5'd31;                          // link register
                end
            end
            mips_pkg::op_beq, mips_pkg::op_bne: begin
                alu = mips_pkg::alu_sub;
                dst = 5'd0;
                off = (ins[31:26] == mips_pkg::op_beq) ? (r1 == r2) : (r1 != r2);
            end
            mips_pkg::op_addi, mips_pkg::op_slti, mips_pkg::op_andi, mips_pkg::op_ori,
            mips_pkg::op_lw: begin
                we  = 1'b1;
                i2  = 5'd0;
                dst = ins[20:16];                         // rt
                op2 = imm;
                case (ins[31:26])
                    mips_pkg::op_slti: alu = mips_pkg::alu_slt;
                    mips_pkg::op_andi: alu = mips_pkg::alu_and;
                    mips_pkg::op_ori:  alu = mips_pkg::alu_or;
                    default:           alu = mips_pkg::alu_add;
                endcase
                if (ins[31:26] == mips_pkg::op_andi || ins[31:26] == mips_pkg::op_ori)
                    op2 = {16'h0000, ins[15:0]};          // logical ops zero-extend
                if (ins[31:26] == mips_pkg::op_lw)
                    mem = 2'b10;
            end
            mips_pkg::op_sw: begin
                alu = mips_pkg::alu_add;
                mem = 2'b01;
                dst = 5'd0;
            end
            default: no_op = 1'b1;
        endcase
        return {no_op, off, ovl, we, mem, alu, op1, op2, r2, i1, i2, dst};
    endfunction

    task automatic check_val(input string name, input logic [31:0] e, input logic [31:0] a);
        if (a !== e) begin
            value_errs++;
            $display("ERR %s expected %h actual %h", name, e, a);
        end
    endtask

    // predict at the edge from inputs driven half a cycle earlier
    always @(posedge clk) begin
        logic [31:0] r1, r2;
        logic [119:0] nb;
        logic [4:0] rs, rt;
        logic uses_rt, load_use;
        rs = id_instruction[25:21];
        rt = id_instruction[20:16];
        armed <= 1'b1;
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) shadow[i] = '0;
            {e_no_op, e_off, e_ovl, e_we, e_mem, e_alu} = {1'b1, 8'h00};
            {e_op1, e_op2, e_sd, e_i1, e_i2, e_dst} = '0;
            check_data = 1'b1;                            // reset zeroes every field
        end else begin
            r1 = (rs == 5'd0) ? '0 : (wb_enable && wb_idx == rs) ? wb_data : shadow[rs];
            r2 = (rt == 5'd0) ? '0 : (wb_enable && wb_idx == rt) ? wb_data : shadow[rt];
            nb = ref_bundle(id_instruction, id_pc_4, r1, r2);
            uses_rt = (id_instruction[31:26] == mips_pkg::op_rtype && !nb[119]) ||
                      id_instruction[31:26] == mips_pkg::op_sw ||
                      id_instruction[31:26] == mips_pkg::op_beq ||
                      id_instruction[31:26] == mips_pkg::op_bne;
            load_use = id_valid && !e_no_op && e_mem[1] && e_dst != 5'd0 &&
                       (rs == e_dst || (uses_rt && rt == e_dst));
            if (stall !== load_use) begin
                stall_errs++;
                $display("ERR stall expected %h actual %h", load_use, stall);
            end
            if (load_use) begin
                {e_no_op, e_off, e_ovl, e_we, e_mem} = 6'b100000;  // held bubble
            end else if (!id_valid || nb[119]) begin
                {e_no_op, e_off, e_ovl, e_we, e_mem} = 6'b100000;
                check_data = 1'b0;                        // data fields are don't care
            end else begin
                {e_no_op, e_off, e_ovl, e_we, e_mem, e_alu,
                 e_op1, e_op2, e_sd, e_i1, e_i2, e_dst} = nb;
                check_data = 1'b1;
            end
            if (wb_enable && wb_idx != 5'd0) shadow[wb_idx] = wb_data;
        end
    end

    // compare mid-cycle when the registered outputs have settled
    always @(negedge clk) begin
        if (armed) begin
            check_val("ex_no_op", {31'd0, e_no_op}, {31'd0, ex_no_op});
            check_val("pc_offset", {31'd0, e_off}, {31'd0, pc_offset});
            check_val("pc_overload", {31'd0, e_ovl}, {31'd0, pc_overload});
            check_val("ex_reg_write_enable", {31'd0, e_we}, {31'd0, ex_reg_write_enable});
            check_val("ex_mem_control", {30'd0, e_mem}, {30'd0, ex_mem_control});
            if (check_data) begin
                check_val("ex_alu_control", {29'd0, e_alu}, {29'd0, ex_alu_control});
                check_val("ex_operand_1", e_op1, ex_operand_1);
                check_val("ex_operand_2", e_op2, ex_operand_2);
                check_val("ex_store_data", e_sd, ex_store_data);
                check_val("ex_reg_1_idx", {27'd0, e_i1}, {27'd0, ex_reg_1_idx});
                check_val("ex_reg_2_idx", {27'd0, e_i2}, {27'd0, ex_reg_2_idx});
                check_val("ex_reg_dest_idx", {27'd0, e_dst}, {27'd0, ex_reg_dest_idx});
            end
        end
    end

endmodule

// File: dv/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;

    logic              clk;
    logic              rst_n;
    logic              id_valid;
    logic [31:0]       id_instruction;
    logic [31:0]       id_pc_4;
    logic              wb_enable;
    logic [4:0]        wb_idx;
    logic [31:0]       wb_data;
    logic              stall;
    logic              ex_no_op, pc_offset, pc_overload, ex_reg_write_enable;
    logic [1:0]        ex_mem_control;
    mips_pkg::alu_op_e ex_alu_control;
    logic [31:0]       ex_operand_1, ex_operand_2, ex_store_data;
    logic [4:0]        ex_reg_1_idx, ex_reg_2_idx, ex_reg_dest_idx;
    int                err_count;
    int                timeouts = 0;
    int                seed;
    logic [31:0]       ins;

    always #5 clk = ~clk;                        // 10 ns period

    decode_stage decode_stage_inst (.*);
    decode_checker decode_checker_inst (.*);

    // occasional writeback next to whatever decode is doing
    task automatic random_wb();
        wb_enable = (($random(seed) & 3) == 0);
        wb_idx    = 5'($random(seed)) & 5'd7;    // low regs collide with sources
        wb_data   = 32'($random(seed));
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            id_valid = 1'b0;
            random_wb();
        end
    endtask

    // offer until stall drops or the retry budget runs out
    task automatic offer(input logic [31:0] instr);
        int tries;
        logic stalled;
        logic [31:0] pc_4;
        tries   = 0;
        stalled = 1'b1;
        pc_4    = 32'($random(seed)) & 32'hffff_fffc;
        while (stalled && tries < 4) begin
            @(negedge clk);
            id_valid       = 1'b1;
            id_instruction = instr;
            id_pc_4        = pc_4;               // same pc on every re-offer
            random_wb();
            #1 stalled = stall;
            tries++;
        end
        if (stalled) begin
            timeouts++;
            $display("stall did not clear after %0d offers of instruction %h", tries, instr);
        end
    endtask

    task automatic next_instr(output logic [31:0] instr);
        logic [3:0]  kind;
        logic [4:0]  rs, rt, rd;
        logic [15:0] imm;
        kind = 4'($random(seed));
        rs   = 5'($random(seed)) & 5'd7;
        rt   = 5'($random(seed)) & 5'd7;
        rd   = 5'($random(seed));
        imm  = 16'($random(seed));
        case (kind)
            4'd0:  instr = {6'h00, rs, rt, rd, 5'd0, 6'h20};   // add
            4'd1:  instr = {6'h00, rs, rt, rd, 5'd0, 6'h22};   // sub
            4'd2:  instr = {6'h00, rs, rt, rd, 5'd0, 6'h24};   // and
            4'd3:  instr = {6'h00, rs, rt, rd, 5'd0, 6'h25};   // or
            4'd4:  instr = {6'h00, rs, rt, rd, 5'd0, 6'h2a};   // slt
            4'd5:  instr = {6'h00, rs, rt, rd, 5'd0, 6'h08};   // jr
            4'd6:  instr = {6'h08, rs, rt, imm};
            4'd7:  instr = {6'h0a, rs, rt, imm};
            4'd8:  instr = {6'h0c, rs, rt, imm};
            4'd9:  instr = {6'h0d, rs, rt, imm};
            4'd10: instr = {6'h23, rs, rt, imm};               // lw
            4'd11: instr = {6'h2b, rs, rt, imm};               // sw
            4'd12: instr = {6'h04, rs, rt, imm};
            4'd13: instr = {6'h05, rs, rt, imm};
            4'd14: instr = {imm[0] ? 6'h03 : 6'h02, rs, rt, imm}; // jal or j
            default: instr = imm[1] ? {6'h3f, rs, rt, imm}     // unknown opcode
                                    : {6'h00, rs, rt, rd, 5'd0, 6'h3f};
        endcase
    endtask

    initial begin
        seed           = 32'hf7e2;
        clk            = 1'b0;
        rst_n          = 1'b0;
        id_valid       = 1'b0;
        id_instruction = '0;
        id_pc_4        = '0;
        wb_enable      = 1'b0;
        wb_idx         = '0;
        wb_data        = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 1; i < 32; i++) begin       // preload the register file
            @(negedge clk);
            wb_enable = 1'b1;
            wb_idx    = 5'(i);
            wb_data   = 32'($random(seed));
        end
        idle(1);
        offer({6'h23, 5'd1, 5'd5, 16'h0010});    // lw r5
        offer({6'h00, 5'd5, 5'd2, 5'd6, 5'd0, 6'h20}); // add r6, r5, r2 must stall once
        offer({6'h3f, 26'h0});                   // illegal, plain bubble
        idle(2);
        for (int n = 0; n < 400; n++) begin
            next_instr(ins);
            offer(ins);
            idle(($random(seed) & 3) == 0 ? 1 : 0);
        end
        idle(2);
        $display("checker errors %0d, timeouts %0d", err_count, timeouts);
        if (err_count == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic [31:0]      instruction,
    output logic             i_type_instruction,  // immediate operand forms incl. lw
    output logic             r_type_instruction,
    output logic             j_instruction,
    output logic             jr_instruction,
    output logic             jal_instruction,
    output logic             branch_instruction,  // beq or bne
    output logic             store_instruction,
    output logic             reg_write_enable,
    output logic             illegal_instruction, // unknown opcode or funct
    output logic [1:0]       mem_control,         // [1] read, [0] write
    output mips_pkg::alu_op_e alu_control,
    output logic             zero_extend          // andi / ori immediates
);

    mips_pkg::opcode_e opcode;
    mips_pkg::funct_e  funct;

    assign opcode = mips_pkg::opcode_e'(instruction[31:26]);
    assign funct  = mips_pkg::funct_e'(instruction[5:0]);

    always_comb begin
        i_type_instruction  = 1'b0;
        r_type_instruction  = 1'b0;
        j_instruction       = 1'b0;
        jr_instruction      = 1'b0;
        jal_instruction     = 1'b0;
        branch_instruction  = 1'b0;
        store_instruction   = 1'b0;
        reg_write_enable    = 1'b0;
        illegal_instruction = 1'b0;
        mem_control         = 2'b00;
        alu_control         = mips_pkg::alu_nop;
        zero_extend         = 1'b0;
        case (opcode)
            mips_pkg::op_rtype: begin
                r_type_instruction = 1'b1;
                reg_write_enable   = 1'b1;               // cleared again for jr
                case (funct)
                    mips_pkg::fn_add: alu_control = mips_pkg::alu_add;
                    mips_pkg::fn_sub: alu_control = mips_pkg::alu_sub;
                    mips_pkg::fn_and: alu_control = mips_pkg::alu_and;
                    mips_pkg::fn_or:  alu_control = mips_pkg::alu_or;
                    mips_pkg::fn_slt: alu_control = mips_pkg::alu_slt;
                    mips_pkg::fn_jr: begin
                        jr_instruction   = 1'b1;
                        reg_write_enable = 1'b0;         // jr only redirects
                    end
                    default: begin
                        r_type_instruction  = 1'b0;
                        reg_write_enable    = 1'b0;
                        illegal_instruction = 1'b1;
                    end
                endcase
            end
            mips_pkg::op_j: j_instruction = 1'b1;
            mips_pkg::op_jal: begin
                jal_instruction  = 1'b1;
                reg_write_enable = 1'b1;                 // link into r31
            end
            mips_pkg::op_beq, mips_pkg::op_bne: begin
                branch_instruction = 1'b1;
                alu_control        = mips_pkg::alu_sub;  // compare by subtraction
            end
            mips_pkg::op_addi, mips_pkg::op_slti, mips_pkg::op_andi, mips_pkg::op_ori,
            mips_pkg::op_lw: begin
                i_type_instruction = 1'b1;
                reg_write_enable   = 1'b1;
                zero_extend = (opcode == mips_pkg::op_andi) || (opcode == mips_pkg::op_ori);
                case (opcode)
                    mips_pkg::op_slti: alu_control = mips_pkg::alu_slt;
                    mips_pkg::op_andi: alu_control = mips_pkg::alu_and;
                    mips_pkg::op_ori:  alu_control = mips_pkg::alu_or;
                    default:           alu_control = mips_pkg::alu_add; // addi, lw address
                endcase
                mem_control[mips_pkg::mem_read_bit] = (opcode == mips_pkg::op_lw);
            end
            mips_pkg::op_sw: begin
                store_instruction = 1'b1;
                alu_control       = mips_pkg::alu_add;   // address calc
                mem_control[mips_pkg::mem_write_bit] = 1'b1;
            end
            default: illegal_instruction = 1'b1;
        endcase
    end

    // redirect kinds must never overlap
    always_comb begin
        assert ($onehot0({j_instruction, jal_instruction, jr_instruction}))
            else $error("control_unit: more than one jump class active");
    end

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              id_valid,          // one-cycle offer strobe
    input  logic [31:0]       id_instruction,
    input  logic [31:0]       id_pc_4,
    input  logic              wb_enable,
    input  logic [4:0]        wb_idx,
    input  logic [31:0]       wb_data,
    output logic              stall,             // re-offer same instruction
    output logic              ex_no_op,
    output logic              pc_offset,
    output logic              pc_overload,
    output logic              ex_reg_write_enable,
    output logic [1:0]        ex_mem_control,
    output mips_pkg::alu_op_e ex_alu_control,
    output logic [31:0]       ex_operand_1,
    output logic [31:0]       ex_operand_2,
    output logic [31:0]       ex_store_data,
    output logic [4:0]        ex_reg_1_idx,
    output logic [4:0]        ex_reg_2_idx,
    output logic [4:0]        ex_reg_dest_idx
);

    logic i_type_instruction, r_type_instruction, j_instruction, jr_instruction;
    logic jal_instruction, branch_instruction, store_instruction;
    logic id_reg_write_enable, illegal_instruction, zero_extend, condition_satisfied;
    logic [1:0]        id_mem_control, hazard_control;
    mips_pkg::alu_op_e id_alu_control;
    logic [31:0]       id_reg_1, id_reg_2, id_sign_extend_result;

    wire [4:0] rs_idx = id_instruction[25:21];
    wire [4:0] rt_idx = id_instruction[20:16];
    wire [4:0] rd_idx = id_instruction[15:11];
    wire branch_on_equal = (id_instruction[31:26] == mips_pkg::op_beq);
    wire uses_rt  = r_type_instruction || store_instruction || branch_instruction;
    wire id_no_op = !id_valid || illegal_instruction;

    control_unit control_unit_inst (
        .instruction(id_instruction), .i_type_instruction, .r_type_instruction,
        .j_instruction, .jr_instruction, .jal_instruction, .branch_instruction,
        .store_instruction, .reg_write_enable(id_reg_write_enable), .illegal_instruction,
        .mem_control(id_mem_control), .alu_control(id_alu_control), .zero_extend
    );

    operand_fetch operand_fetch_inst (
        .clk, .rst_n, .rs_idx, .rt_idx, .immediate(id_instruction[15:0]), .zero_extend,
        .branch_instruction, .branch_on_equal, .wb_enable, .wb_idx, .wb_data,
        .reg_1(id_reg_1), .reg_2(id_reg_2), .sign_extend_result(id_sign_extend_result),
        .condition_satisfied
    );

    hazard_unit hazard_unit_inst (
        .clk, .rst_n, .id_valid, .rs_idx, .rt_idx, .uses_rt, .ex_mem_control,
        .ex_reg_dest_idx, .ex_no_op, .hazard_control, .stall
    );

    id_ex_reg id_ex_reg_inst (
        .clk, .rst_n, .hazard_control, .id_no_op, .ex_no_op, .i_type_instruction,
        .r_type_instruction, .j_instruction, .jr_instruction, .jal_instruction,
        .branch_instruction, .store_instruction, .condition_satisfied, .pc_offset,
        .pc_overload, .id_reg_write_enable, .ex_reg_write_enable, .id_mem_control,
        .ex_mem_control, .id_alu_control, .ex_alu_control, .id_reg_1, .id_reg_2,
        .id_instruction, .id_pc_4, .id_sign_extend_result, .ex_operand_1, .ex_operand_2,
        .ex_store_data, .id_reg_1_idx(rs_idx), .id_reg_2_idx(rt_idx),
        .id_reg_dest_idx(rd_idx), .ex_reg_1_idx, .ex_reg_2_idx, .ex_reg_dest_idx
    );

endmodule

// File: rtl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  logic       clk,               // assertion sampling only
    input  logic       rst_n,
    input  logic       id_valid,
    input  logic [4:0] rs_idx,
    input  logic [4:0] rt_idx,
    input  logic       uses_rt,           // r type, store, branch
    input  logic [1:0] ex_mem_control,
    input  logic [4:0] ex_reg_dest_idx,
    input  logic       ex_no_op,
    output logic [1:0] hazard_control,
    output logic       stall
);

    logic live_load;                      // load sitting in ex with a real target
    logic load_use;

    assign live_load = !ex_no_op && ex_mem_control[mips_pkg::mem_read_bit] &&
                       (ex_reg_dest_idx != '0);
    assign load_use  = id_valid && live_load &&
                       ((rs_idx == ex_reg_dest_idx) || (uses_rt && (rt_idx == ex_reg_dest_idx)));

    always_comb begin
        hazard_control = 2'b00;
        hazard_control[mips_pkg::hazd_hold_bit]  = load_use;  // freeze ex data
        hazard_control[mips_pkg::hazd_no_op_bit] = load_use;  // bubble into ex
    end

    assign stall = load_use;              // source re-offers next cycle

    // the bubble after a stall retires the load, so no second stall for it
    assert property (@(posedge clk) disable iff (!rst_n) stall |=> !stall)
        else $error("hazard_unit: stall raised twice for one load");

endmodule

// File: rtl/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [1:0]        hazard_control,
    input  logic              id_no_op,               // idle or illegal in decode
    output logic              ex_no_op,
    input  logic              i_type_instruction,
    input  logic              r_type_instruction,
    input  logic              j_instruction,
    input  logic              jr_instruction,
    input  logic              jal_instruction,
    input  logic              branch_instruction,
    input  logic              store_instruction,
    input  logic              condition_satisfied,
    output logic              pc_offset,              // taken branch
    output logic              pc_overload,            // any jump
    input  logic              id_reg_write_enable,
    output logic              ex_reg_write_enable,
    input  logic [1:0]        id_mem_control,
    output logic [1:0]        ex_mem_control,
    input  mips_pkg::alu_op_e id_alu_control,
    output mips_pkg::alu_op_e ex_alu_control,
    input  logic [31:0]       id_reg_1,
    input  logic [31:0]       id_reg_2,
    input  logic [31:0]       id_instruction,
    input  logic [31:0]       id_pc_4,
    input  logic [31:0]       id_sign_extend_result,
    output logic [31:0]       ex_operand_1,
    output logic [31:0]       ex_operand_2,
    output logic [31:0]       ex_store_data,
    input  logic [4:0]        id_reg_1_idx,
    input  logic [4:0]        id_reg_2_idx,
    input  logic [4:0]        id_reg_dest_idx,
    output logic [4:0]        ex_reg_1_idx,
    output logic [4:0]        ex_reg_2_idx,
    output logic [4:0]        ex_reg_dest_idx
);

    logic bubble;                    // nothing real enters ex this cycle
    logic hold;                      // keep ex data from last cycle
    logic jump_target;               // j or jal
    logic no_dest;                   // store or branch
    logic [mips_pkg::reg_idx_width-1:0] dest_idx;

    assign bubble      = hazard_control[mips_pkg::hazd_no_op_bit] || id_no_op;
    assign hold        = hazard_control[mips_pkg::hazd_hold_bit];
    assign jump_target = j_instruction || jal_instruction;
    assign no_dest     = store_instruction || branch_instruction;

    always_comb begin
        if (i_type_instruction)   dest_idx = id_reg_2_idx;           // rt
        else if (no_dest)         dest_idx = '0;
        else if (jal_instruction) dest_idx = mips_pkg::ret_reg_idx;
        else if (jr_instruction)  dest_idx = id_reg_1_idx;           // rs
        else                      dest_idx = id_reg_dest_idx;        // rd
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_no_op            <= 1'b1;                 // ex starts idle
            pc_offset           <= 1'b0;
            pc_overload         <= 1'b0;
            ex_reg_write_enable <= 1'b0;
            ex_mem_control      <= 2'b00;
            ex_alu_control      <= mips_pkg::alu_nop;
            ex_operand_1        <= '0;
            ex_operand_2        <= '0;
            ex_store_data       <= '0;
            ex_reg_1_idx        <= '0;
            ex_reg_2_idx        <= '0;
            ex_reg_dest_idx     <= '0;
        end else begin
            ex_no_op            <= bubble;
            pc_offset           <= !bubble && branch_instruction && condition_satisfied;
            pc_overload         <= !bubble && (jump_target || jr_instruction);
            ex_reg_write_enable <= !bubble && id_reg_write_enable;
            ex_mem_control      <= bubble ? 2'b00 : id_mem_control;
            if (!hold) begin
                ex_alu_control <= id_alu_control;
                ex_operand_1   <= jump_target
                    ? {id_pc_4[mips_pkg::isa_width-1:mips_pkg::addr_width+2],
                       id_instruction[mips_pkg::addr_width-1:0], 2'b00}
                    : id_reg_1;
                ex_operand_2    <= i_type_instruction ? id_sign_extend_result : id_reg_2;
                ex_store_data   <= id_reg_2;
                ex_reg_1_idx    <= jump_target ? '0 : id_reg_1_idx;   // jumps read no rs
                ex_reg_2_idx    <= (r_type_instruction || no_dest) ? id_reg_2_idx : '0;
                ex_reg_dest_idx <= dest_idx;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(pc_offset && pc_overload))
        else $error("id_ex_reg: branch and jump redirect at once");

endmodule

// File: rtl/mips_pkg.sv
package mips_pkg;

    localparam int isa_width      = 32;         // data and instruction width
    localparam int reg_idx_width  = 5;          // register index width
    localparam int addr_width     = 26;         // j/jal target field
    localparam logic [4:0] ret_reg_idx = 5'd31; // jal link register

    localparam int hazd_hold_bit  = 1;          // hazard_control: keep ex data
    localparam int hazd_no_op_bit = 0;          // hazard_control: bubble into ex
    localparam int mem_read_bit   = 1;          // mem_control read strobe
    localparam int mem_write_bit  = 0;          // mem_control write strobe

    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_jal   = 6'h03,
        op_beq   = 6'h04,
        op_bne   = 6'h05,
        op_addi  = 6'h08,
        op_slti  = 6'h0a,
        op_andi  = 6'h0c,
        op_ori   = 6'h0d,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        fn_jr  = 6'h08,
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        alu_nop = 3'd0,
        alu_add = 3'd1,
        alu_sub = 3'd2,
        alu_and = 3'd3,
        alu_or  = 3'd4,
        alu_slt = 3'd5
    } alu_op_e;

endpackage

// File: rtl/operand_fetch.sv
`timescale 1ns/1ps

module operand_fetch (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs_idx,
    input  logic [4:0]  rt_idx,
    input  logic [15:0] immediate,
    input  logic        zero_extend,         // andi / ori
    input  logic        branch_instruction,
    input  logic        branch_on_equal,     // beq when high, bne when low
    input  logic        wb_enable,
    input  logic [4:0]  wb_idx,
    input  logic [31:0] wb_data,
    output logic [31:0] reg_1,
    output logic [31:0] reg_2,
    output logic [31:0] sign_extend_result,
    output logic        condition_satisfied
);

    logic [mips_pkg::isa_width-1:0] regs [32];
    logic wb_live;                            // a write that actually lands

    assign wb_live = wb_enable && (wb_idx != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_live) begin
            regs[wb_idx] <= wb_data;          // r0 never written
        end
    end

    // write-through so decode sees this cycle's writeback
    always_comb begin
        if (rs_idx == '0)                        reg_1 = '0;
        else if (wb_live && (wb_idx == rs_idx))  reg_1 = wb_data;
        else                                     reg_1 = regs[rs_idx];
        if (rt_idx == '0)                        reg_2 = '0;
        else if (wb_live && (wb_idx == rt_idx))  reg_2 = wb_data;
        else                                     reg_2 = regs[rt_idx];
    end

    assign sign_extend_result = zero_extend ? {16'h0000, immediate}
                                            : {{16{immediate[15]}}, immediate};

    assign condition_satisfied = branch_instruction &&
                                 (branch_on_equal ? (reg_1 == reg_2) : (reg_1 != reg_2));

endmodule
